// ==== build.f ====
rtl/flow_pkg.sv
rtl/alu_pkg.sv
rtl/op_issue.sv
rtl/op_queue.sv
rtl/alu_exec.sv
rtl/alu_top.sv
dv/alu_checker.sv
dv/alu_tb.sv

// ==== dv/alu_checker.sv ====
// concurrent checks on the credit loop and the result port
// bound into alu_top, reads the credit counter inside issue_i and the queue occupancy
`timescale 1ns/1ps
`default_nettype none

module alu_checker
  import flow_pkg::*, alu_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic [credit_w-1:0] credits,
  input logic [credit_w-1:0] occupancy,
  input logic                push,
  input alu_result_t         res,
  input logic                res_valid,
  input logic                res_ready
);

  credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= credit_w'(queue_depth))
    else $error("credit count above queue depth");

  // a granted credit must always mean a free queue entry
  push_has_room: assert property (@(posedge clk) disable iff (rst)
    push |-> occupancy < credit_w'(queue_depth))
    else $error("push into a full queue");

  // held result must not move until taken
  res_hold: assert property (@(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid && $stable(res))
    else $error("result changed while stalled");

endmodule

bind alu_top alu_checker checker_i (
  .clk       (clk),
  .rst       (rst),
  .credits   (issue_i.credits),
  .occupancy (queue_i.count),
  .push      (issue_i.push),
  .res       (res),
  .res_valid (res_valid),
  .res_ready (res_ready)
);

`default_nettype wire

// ==== dv/alu_tb.sv ====
// directed and random tests of alu_top against a model of the ALU rules
// the model keeps its own flags and tag, results are checked in order
// stops at the first mismatch or timeout
`timescale 1ns/1ps
`default_nettype none

module alu_tb
  import alu_pkg::*, flow_pkg::*;
();

  logic             clk;
  logic             rst;
  alu_cmd_t         cmd;
  logic             cmd_valid;
  logic             cmd_ready;
  alu_result_t      res;
  logic             res_valid;
  logic             res_ready;

  alu_result_t      exp_q[$];
  alu_result_t      last_res;
  flags_t           m_flags;
  logic [tag_w-1:0] m_tag;
  logic [31:0]      lcg_state;
  logic             rand_done;
  int               err_cnt;

  alu_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("ERROR %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_timeout(input string msg);
    err_cnt++;
    $display("timeout at %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic compare_flags(input flags_t got, input flags_t want, input string what);
    if (got !== want) begin
      report_mismatch($sformatf("%s: flags cszv %b, expected %b", what, got, want));
    end
  endtask

  task automatic compare_result(input alu_result_t got, input alu_result_t want,
                                input string what);
    compare_flags(got.flags, want.flags, what);
    if (got.tag !== want.tag || got.result !== want.result ||
        got.executed !== want.executed) begin
      report_mismatch($sformatf("%s: tag %0d result %h exec %b, expected tag %0d result %h exec %b",
                                what, got.tag, got.result, got.executed,
                                want.tag, want.result, want.executed));
    end
  endtask

  task automatic compare_data(input logic [data_w-1:0] got, input logic [data_w-1:0] want,
                              input string what);
    if (got !== want) begin
      report_mismatch($sformatf("%s: %h, expected %h", what, got, want));
    end
  endtask

  task automatic compare_level(input logic got, input logic want, input string what);
    if (got !== want) begin
      report_mismatch($sformatf("%s: %b, expected %b", what, got, want));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic alu_cmd_t make_cmd(input alu_op_e op, input cond_e cond,
                                        input logic [31:0] a, input logic [31:0] b);
    alu_cmd_t c;
    c         = '0;
    c.op      = op;
    c.cond    = cond;
    c.a       = a;
    c.b       = b;
    return c;
  endfunction

  // expected result of one accepted command, flags and tag advance here
  task automatic model_push(input alu_cmd_t c);
    logic [31:0] b;
    logic [31:0] r;
    logic [32:0] wide;
    longint      s;
    logic        hold;
    flags_t      f;
    alu_result_t e;
    b = c.use_imm ? {{16{c.imm[15]}}, c.imm} : c.b;
    f = '0;
    case (c.op)
      op_add: begin
        wide       = {1'b0, c.a} + {1'b0, b};
        r          = wide[31:0];
        f.carry    = wide[32];
        s          = longint'($signed(c.a)) + longint'($signed(b));
        f.overflow = (s != longint'($signed(r)));  // true sum does not fit
      end
      op_sub: begin
        r          = c.a - b;
        f.carry    = (c.a >= b);
        s          = longint'($signed(c.a)) - longint'($signed(b));
        f.overflow = (s != longint'($signed(r)));
      end
      op_and:  r = c.a & b;
      op_or:   r = c.a | b;
      op_xor:  r = c.a ^ b;
      op_shl:  r = c.a << b[4:0];
      op_sxtb: r = {{24{c.a[7]}}, c.a[7:0]};
      default: r = b;
    endcase
    f.sign = r[31];
    f.zero = (r == 32'd0);
    case (c.cond)
      cond_eq: hold = m_flags.zero;
      cond_ne: hold = !m_flags.zero;
      cond_cs: hold = m_flags.carry;
      cond_cc: hold = !m_flags.carry;
      cond_mi: hold = m_flags.sign;
      cond_pl: hold = !m_flags.sign;
      cond_vs: hold = m_flags.overflow;
      default: hold = 1'b1;
    endcase
    e.tag      = m_tag;
    e.executed = hold;
    e.result   = hold ? r : c.a;
    e.flags    = hold ? f : m_flags;
    m_flags    = e.flags;
    m_tag      = m_tag + 1'b1;
    exp_q.push_back(e);
  endtask

  // called a little after a rising edge, returns at the same phase
  task automatic send_cmd(input alu_cmd_t c);
    int waited;
    waited    = 0;
    cmd       = c;
    cmd_valid = 1'b1;
    @(negedge clk);
    while (!cmd_ready) begin
      waited++;
      if (waited > 100) report_timeout("command not accepted within 100 cycles");
      @(negedge clk);
    end
    model_push(c);
    @(posedge clk);
    #10;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #10;
      waited++;
      if (waited > 200) report_timeout("results did not drain within 200 cycles");
    end
  endtask

  task automatic test_reset();
    compare_level(cmd_ready, 1'b1, "cmd_ready after reset");
    compare_level(res_valid, 1'b0, "res_valid after reset");
    send_cmd(make_cmd(op_add, cond_eq, 32'd5, 32'd7));  // zero clear, so skipped
    wait_drain();
    compare_data(32'(last_res.tag), 32'd0, "first tag");
    compare_flags(last_res.flags, '0, "flags after reset");
  endtask

  task automatic test_ops();
    send_cmd(make_cmd(op_add, cond_al, 32'hffff_ffff, 32'd1));  // carry out
    send_cmd(make_cmd(op_add, cond_al, 32'h7fff_ffff, 32'd1));  // signed overflow
    send_cmd(make_cmd(op_sub, cond_al, 32'd3, 32'd5));          // borrow
    send_cmd(make_cmd(op_sub, cond_al, 32'h8000_0000, 32'd1));
    send_cmd(make_cmd(op_and, cond_al, 32'hf0f0_1234, 32'h0ff0_ffff));
    send_cmd(make_cmd(op_or, cond_al, 32'h8000_0000, 32'h0000_0001));
    send_cmd(make_cmd(op_xor, cond_al, 32'h5a5a_5a5a, 32'h5a5a_5a5a));
    send_cmd(make_cmd(op_shl, cond_al, 32'h0000_00f1, 32'd36));  // only b[4:0] counts
    send_cmd(make_cmd(op_sxtb, cond_al, 32'h1234_5680, 32'd0));
    send_cmd(make_cmd(op_mov, cond_al, 32'd9, 32'hcafe_0001));
    wait_drain();
  endtask

  task automatic cond_pair(input alu_cmd_t set_fail, input cond_e fail_c,
                           input alu_cmd_t set_hold, input cond_e hold_c);
    send_cmd(set_fail);
    send_cmd(make_cmd(op_add, fail_c, 32'h1234, 32'd1));
    wait_drain();
    compare_level(last_res.executed, 1'b0, "failed condition");
    send_cmd(set_hold);
    send_cmd(make_cmd(op_or, hold_c, 32'h0f0, 32'h00f));
    wait_drain();
    compare_level(last_res.executed, 1'b1, "held condition");
  endtask

  task automatic test_cond();
    alu_cmd_t z_set;
    z_set = make_cmd(op_sub, cond_al, 32'd5, 32'd5);
    cond_pair(z_set, cond_ne, z_set, cond_eq);
    cond_pair(make_cmd(op_add, cond_al, 32'd1, 32'd1), cond_cs,
              make_cmd(op_add, cond_al, 32'hffff_fff0, 32'h20), cond_cs);
    cond_pair(make_cmd(op_sub, cond_al, 32'd1, 32'd2), cond_pl,
              make_cmd(op_sub, cond_al, 32'd1, 32'd2), cond_mi);
    cond_pair(z_set, cond_vs, make_cmd(op_add, cond_al, 32'h7fff_ffff, 32'd1), cond_vs);
  endtask

  task automatic test_imm();
    alu_cmd_t c;
    c         = make_cmd(op_mov, cond_al, 32'h1111, 32'hdead_beef);
    c.use_imm = 1'b1;
    c.imm     = 16'h8001;
    send_cmd(c);
    wait_drain();
    compare_data(last_res.result, 32'hffff_8001, "mov of negative imm");
    c.op = op_add;
    c.a  = 32'h10;
    c.imm = 16'hfff0;  // -16, sum is zero
    send_cmd(c);
    wait_drain();
  endtask

  task automatic test_backpressure();
    alu_cmd_t c;
    int accepted;
    int stalled;
    int cycles;
    accepted  = 0;
    stalled   = 0;
    cycles    = 0;
    res_ready = 1'b0;
    cmd_valid = 1'b1;
    while (stalled < 4) begin
      c   = make_cmd(op_add, cond_al, 32'(accepted), 32'd1);
      cmd = c;
      @(negedge clk);
      if (cmd_ready) begin
        model_push(c);
        accepted++;
        stalled = 0;
      end else begin
        stalled++;
      end
      cycles++;
      if (cycles > 20) report_timeout("cmd_ready never dropped under back-pressure");
      @(posedge clk);
      #10;
    end
    cmd_valid = 1'b0;
    // output register plus a full queue
    if (accepted != queue_depth + 1) begin
      report_mismatch($sformatf("%0d commands accepted under back-pressure, expected %0d",
                                accepted, queue_depth + 1));
    end
    compare_level(cmd_ready, 1'b0, "cmd_ready while stalled");
    res_ready = 1'b1;
    wait_drain();
  endtask

  task automatic test_random();
    alu_cmd_t    c;
    logic [31:0] r;
    logic [31:0] t;
    int          n;
    n         = 0;
    rand_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 200; i++) begin
          r         = lcg_next();
          c.op      = alu_op_e'(r[2:0]);
          c.cond    = cond_e'(r[5:3]);
          c.use_imm = r[6];
          c.imm     = r[31:16];
          c.a       = lcg_next();
          c.b       = r[7] ? c.a : lcg_next();  // equal operands now and then
          send_cmd(c);
        end
        rand_done = 1'b1;
      end
      begin
        while (!rand_done) begin
          @(negedge clk);
          t = lcg_next();  // drawn between the command draws
          @(posedge clk);
          #10;
          res_ready = t[9];
          n++;
          if (n > 50000) report_timeout("random stream did not finish");
        end
      end
    join
    res_ready = 1'b1;
    wait_drain();
  endtask

  // a transfer happens on the next rising edge, both sides are stable here
  always @(negedge clk) begin
    if (!rst && res_valid && res_ready) begin
      if (exp_q.size() == 0) begin
        report_mismatch("result came out with no command outstanding");
      end else begin
        compare_result(res, exp_q.pop_front(), "result");
        last_res = res;
      end
    end
  end

  initial begin
    rst       = 1'b1;
    cmd       = '0;
    cmd_valid = 1'b0;
    res_ready = 1'b1;
    m_flags   = '0;
    m_tag     = '0;
    last_res  = '0;
    lcg_state = 32'ha3da;
    rand_done = 1'b0;
    err_cnt   = 0;
    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;
    test_reset();
    test_ops();
    test_cond();
    test_imm();
    test_backpressure();
    test_random();
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/alu_exec.sv ====
// execute stage: condition test against the flag register, then ALU
// a failed condition returns a with the flags left as they were
// one result register, refilled on the same edge it is drained
`timescale 1ns/1ps
`default_nettype none

module alu_exec
  import alu_pkg::*, flow_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  issue_pkt_t  head,
  input  logic        not_empty,
  output logic        pop,
  output alu_result_t res,
  output logic        res_valid,
  input  logic        res_ready
);

  flags_t            flags;
  flags_t            flags_next;
  alu_op_e           op;
  cond_e             cond;
  logic [data_w:0]   sum;
  logic [data_w-1:0] diff;
  logic [data_w-1:0] calc;
  logic              calc_c;
  logic              calc_v;
  logic              take;
  logic [data_w-1:0] result;

  function automatic logic cond_hold(cond_e c, flags_t f);
    case (c)
      cond_eq: cond_hold = f.zero;
      cond_ne: cond_hold = !f.zero;
      cond_cs: cond_hold = f.carry;
      cond_cc: cond_hold = !f.carry;
      cond_mi: cond_hold = f.sign;
      cond_pl: cond_hold = !f.sign;
      cond_vs: cond_hold = f.overflow;
      default: cond_hold = 1'b1;  // cond_al
    endcase
  endfunction

  assign op   = alu_op_e'(head.op);
  assign cond = cond_e'(head.cond);
  assign take = cond_hold(cond, flags);

  always_comb begin
    sum    = {1'b0, head.a} + {1'b0, head.b};
    diff   = head.a - head.b;
    calc_c = 1'b0;
    calc_v = 1'b0;
    case (op)
      op_add: begin
        calc   = sum[data_w-1:0];
        calc_c = sum[data_w];
        calc_v = (head.a[data_w-1] == head.b[data_w-1]) &&
                 (sum[data_w-1] != head.a[data_w-1]);
      end
      op_sub: begin
        calc   = diff;
        calc_c = (head.a >= head.b);  // no borrow
        calc_v = (head.a[data_w-1] != head.b[data_w-1]) &&
                 (diff[data_w-1] != head.a[data_w-1]);
      end
      op_and:  calc = head.a & head.b;
      op_or:   calc = head.a | head.b;
      op_xor:  calc = head.a ^ head.b;
      op_shl:  calc = head.a << head.b[4:0];
      op_sxtb: calc = {{(data_w-8){head.a[7]}}, head.a[7:0]};
      default: calc = head.b;  // op_mov
    endcase
  end

  always_comb begin
    if (take) begin
      result              = calc;
      flags_next.carry    = calc_c;
      flags_next.sign     = calc[data_w-1];
      flags_next.zero     = (calc == '0);
      flags_next.overflow = calc_v;
    end else begin
      result     = head.a;  // fall-through value
      flags_next = flags;
    end
  end

  // take the head when the output slot is free or draining now
  assign pop = not_empty && (!res_valid || res_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      flags     <= '0;
      res_valid <= 1'b0;
    end else begin
      if (pop) begin
        flags     <= flags_next;
        res_valid <= 1'b1;
      end else if (res_ready) begin
        res_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      res.tag      <= head.tag;
      res.result   <= result;
      res.flags    <= flags_next;
      res.executed <= take;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/alu_pkg.sv ====
// command, flag and result types of the conditional integer ALU
// the result carries the sequence tag, so this package depends on flow_pkg
// flow_pkg has to be compiled first
`default_nettype none

package alu_pkg;
  import flow_pkg::*;

  localparam int data_w = 32;
  localparam int imm_w  = 16;

  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_shl  = 3'd5,  // by b[4:0]
    op_sxtb = 3'd6,  // low byte of a
    op_mov  = 3'd7
  } alu_op_e;

  typedef enum logic [2:0] {
    cond_al = 3'd0,
    cond_eq = 3'd1,
    cond_ne = 3'd2,
    cond_cs = 3'd3,
    cond_cc = 3'd4,
    cond_mi = 3'd5,
    cond_pl = 3'd6,
    cond_vs = 3'd7
  } cond_e;

  typedef struct packed {
    logic carry;
    logic sign;
    logic zero;
    logic overflow;
  } flags_t;

  typedef struct packed {
    alu_op_e           op;
    cond_e             cond;
    logic              use_imm;  // take imm instead of b
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [imm_w-1:0]  imm;
  } alu_cmd_t;

  typedef struct packed {
    logic [tag_w-1:0]  tag;
    logic [data_w-1:0] result;
    flags_t            flags;
    logic              executed;  // condition held
  } alu_result_t;

endpackage

`default_nettype wire

// ==== rtl/alu_top.sv ====
// conditional integer ALU: issue, packet queue and execute in a row
// commands in and results out on valid/ready, results in command order
// res_ready low for long stalls cmd_ready after at most 5 commands
`timescale 1ns/1ps
`default_nettype none

module alu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  alu_pkg::alu_cmd_t    cmd,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  output alu_pkg::alu_result_t res,
  output logic                 res_valid,
  input  logic                 res_ready
);

  flow_pkg::issue_pkt_t pkt;
  flow_pkg::issue_pkt_t head;
  logic                 push;
  logic                 pop;
  logic                 not_empty;
  logic                 credit_return;

  op_issue issue_i (
    .clk           (clk),
    .rst           (rst),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .credit_return (credit_return),
    .pkt           (pkt),
    .push          (push)
  );

  op_queue queue_i (
    .clk           (clk),
    .rst           (rst),
    .pkt           (pkt),
    .push          (push),
    .head          (head),
    .not_empty     (not_empty),
    .pop           (pop),
    .credit_return (credit_return)
  );

  alu_exec exec_i (
    .clk       (clk),
    .rst       (rst),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

endmodule

`default_nettype wire

// ==== rtl/flow_pkg.sv ====
// queue and credit sizing for the issue to execute path
// queue_depth must be a power of two since the queue pointers wrap freely
// op and cond are carried as raw 3-bit codes, decoded with the alu_pkg enums
`default_nettype none

package flow_pkg;

  localparam int queue_depth = 4;
  localparam int credit_w    = 3;  // counts 0..queue_depth
  localparam int ptr_w       = $clog2(queue_depth);
  localparam int tag_w       = 4;  // wraps mod 16

  // one queued operation, b already selected between register and imm
  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [2:0]       op;
    logic [2:0]       cond;
    logic [31:0]      a;
    logic [31:0]      b;
  } issue_pkt_t;

endpackage

`default_nettype wire

// ==== rtl/op_issue.sv ====
// command intake with credit based flow control toward op_queue
// starts with queue_depth credits, one per free queue entry
// cmd_ready is combinational from the credit count only
`timescale 1ns/1ps
`default_nettype none

module op_issue
  import flow_pkg::*, alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  alu_cmd_t   cmd,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  logic       credit_return,
  output issue_pkt_t pkt,
  output logic       push
);

  logic [credit_w-1:0] credits;
  logic [tag_w-1:0]    tag_cnt;
  logic [data_w-1:0]   imm_ext;

  assign cmd_ready = (credits != '0);
  assign push      = cmd_valid && cmd_ready;

  assign imm_ext = {{(data_w-imm_w){cmd.imm[imm_w-1]}}, cmd.imm};

  always_comb begin
    pkt.tag  = tag_cnt;
    pkt.op   = cmd.op;
    pkt.cond = cmd.cond;
    pkt.a    = cmd.a;
    pkt.b    = cmd.use_imm ? imm_ext : cmd.b;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_w'(queue_depth);
      tag_cnt <= '0;
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither
      endcase
      if (push) begin
        tag_cnt <= tag_cnt + 1'b1;  // wraps mod 16
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/op_queue.sv ====
// in-order circular buffer of issue packets
// no full flag, the sender's credits keep it from overflowing
// each pop hands one credit back on the following cycle
`timescale 1ns/1ps
`default_nettype none

module op_queue
  import flow_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  issue_pkt_t pkt,
  input  logic       push,
  output issue_pkt_t head,
  output logic       not_empty,
  input  logic       pop,
  output logic       credit_return
);

  issue_pkt_t          mem [queue_depth];
  logic [ptr_w-1:0]    wr_ptr;
  logic [ptr_w-1:0]    rd_ptr;
  logic [credit_w-1:0] count;

  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= pkt;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_return <= pop;  // one pulse per freed entry
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run alu_tb with Verilator, pass or fail is read from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module alu_tb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Valu_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if ! grep -q "Verification passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
